// File: design/uart_cmd_settings.svh
`ifndef UART_CMD_SETTINGS_SVH
`define UART_CMD_SETTINGS_SVH

// clocks per bit time, 4 or more
`define UART_CLKS_PER_BIT 16

// command fields
`define UART_ADDR_W 7
`define UART_DATA_W 8

// start + data + parity + stop
`define UART_FRAME_BITS 11

`endif

// File: design/uart_cmd_pkg.sv
`default_nettype none

`include "uart_cmd_settings.svh"

package uart_cmd_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  // host command word, op in bit 15
  typedef struct packed {
    cmd_op_e                 op;
    logic [`UART_ADDR_W-1:0] addr;
    logic [`UART_DATA_W-1:0] data;
  } cmd_word_t;

  typedef struct packed {
    logic [`UART_DATA_W-1:0] payload;
  } byte_req_t;

  typedef struct packed {
    logic [`UART_DATA_W-1:0] data;
    logic                    error;
  } rx_result_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_HEADER,
    SEQ_DATA,
    SEQ_WAIT_RESP,
    SEQ_DELIVER
  } seq_state_e;

  typedef enum logic {
    SER_IDLE,
    SER_SHIFT
  } ser_state_e;

  typedef enum logic [1:0] {
    DES_IDLE,
    DES_START,
    DES_BITS,
    DES_STOP
  } des_state_e;

endpackage

`default_nettype wire

// File: design/cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_cmd_settings.svh"

module cmd_sequencer (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire uart_cmd_pkg::cmd_word_t  cmd,
  input  wire                      cmd_valid,
  output logic                     cmd_ready,
  output uart_cmd_pkg::byte_req_t  byte_req,
  output logic                     byte_valid,
  input  wire                      byte_ready,
  input  wire uart_cmd_pkg::rx_result_t frame_result,
  input  wire                      frame_valid,
  output uart_cmd_pkg::rx_result_t rd_result,
  output logic                     rd_valid,
  input  wire                      rd_ready
);

  uart_cmd_pkg::seq_state_e state;
  uart_cmd_pkg::seq_state_e state_nxt;
  uart_cmd_pkg::cmd_word_t  cmd_q;
  uart_cmd_pkg::rx_result_t resp_q;
  logic                     is_write;

  assign is_write = (cmd_q.op == uart_cmd_pkg::OP_WRITE);

  always_comb begin
    state_nxt = state;
    case (state)
      uart_cmd_pkg::SEQ_IDLE: begin
        if (cmd_valid) begin
          state_nxt = uart_cmd_pkg::SEQ_HEADER;
        end
      end
      uart_cmd_pkg::SEQ_HEADER: begin
        if (byte_ready) begin
          state_nxt = is_write ? uart_cmd_pkg::SEQ_DATA : uart_cmd_pkg::SEQ_WAIT_RESP;
        end
      end
      uart_cmd_pkg::SEQ_DATA: begin
        if (byte_ready) begin
          state_nxt = uart_cmd_pkg::SEQ_IDLE;
        end
      end
      uart_cmd_pkg::SEQ_WAIT_RESP: begin
        if (frame_valid) begin
          state_nxt = uart_cmd_pkg::SEQ_DELIVER;
        end
      end
      uart_cmd_pkg::SEQ_DELIVER: begin
        if (rd_ready) begin
          state_nxt = uart_cmd_pkg::SEQ_IDLE;
        end
      end
      default: state_nxt = uart_cmd_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_cmd_pkg::SEQ_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      cmd_q <= cmd;
    end
    // only the first frame after the header counts
    if (frame_valid && state == uart_cmd_pkg::SEQ_WAIT_RESP) begin
      resp_q <= frame_result;
    end
  end

  assign cmd_ready  = (state == uart_cmd_pkg::SEQ_IDLE);
  assign byte_valid = (state == uart_cmd_pkg::SEQ_HEADER) || (state == uart_cmd_pkg::SEQ_DATA);

  // header is op bit over the address
  assign byte_req.payload = (state == uart_cmd_pkg::SEQ_DATA) ? cmd_q.data
                                                              : {cmd_q.op, cmd_q.addr};

  assign rd_valid  = (state == uart_cmd_pkg::SEQ_DELIVER);
  assign rd_result = resp_q;

endmodule

`default_nettype wire

// File: design/frame_serializer.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_cmd_settings.svh"

module frame_serializer (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire uart_cmd_pkg::byte_req_t byte_req,
  input  wire                          byte_valid,
  output logic                         byte_ready,
  output logic                         tx
);

  localparam int BAUD_W = $clog2(`UART_CLKS_PER_BIT);

  uart_cmd_pkg::ser_state_e     state;
  logic [BAUD_W-1:0]            baud_cnt;
  logic [3:0]                   bit_cnt;
  logic [`UART_FRAME_BITS-1:0]  shreg;
  logic                         parity;
  logic                         bit_end;

  // odd parity over the payload
  assign parity  = ~^byte_req.payload;
  assign bit_end = (baud_cnt == BAUD_W'(`UART_CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_cmd_pkg::SER_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      shreg    <= '1;
    end else begin
      case (state)
        uart_cmd_pkg::SER_IDLE: begin
          if (byte_valid) begin
            // stop, parity, data lsb first, start
            shreg    <= {1'b1, parity, byte_req.payload, 1'b0};
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= uart_cmd_pkg::SER_SHIFT;
          end
        end
        uart_cmd_pkg::SER_SHIFT: begin
          if (bit_end) begin
            baud_cnt <= '0;
            shreg    <= {1'b1, shreg[`UART_FRAME_BITS-1:1]};
            if (bit_cnt == 4'(`UART_FRAME_BITS - 1)) begin
              bit_cnt <= '0;
              state   <= uart_cmd_pkg::SER_IDLE;
            end else begin
              bit_cnt <= bit_cnt + 4'd1;
            end
          end else begin
            baud_cnt <= baud_cnt + BAUD_W'(1);
          end
        end
        default: state <= uart_cmd_pkg::SER_IDLE;
      endcase
    end
  end

  assign byte_ready = (state == uart_cmd_pkg::SER_IDLE);

  // line idles high since shreg refills with ones
  assign tx = shreg[0];

endmodule

`default_nettype wire

// File: design/frame_deserializer.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_cmd_settings.svh"

module frame_deserializer (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           rx,
  output uart_cmd_pkg::rx_result_t      frame_result,
  output logic                          frame_valid
);

  localparam int BAUD_W = $clog2(`UART_CLKS_PER_BIT);

  uart_cmd_pkg::des_state_e    state;
  logic                        rx_meta;
  logic                        rx_sync;
  logic                        rx_prev;
  logic                        fall;
  logic [BAUD_W-1:0]           baud_cnt;
  logic [3:0]                  bit_cnt;
  logic [`UART_DATA_W:0]       shreg;
  logic                        half_bit;
  logic                        full_bit;
  logic                        parity_bad;

  // two-flop synchronizer, then edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall     = rx_prev && !rx_sync;
  assign half_bit = (baud_cnt == BAUD_W'(`UART_CLKS_PER_BIT / 2 - 1));
  assign full_bit = (baud_cnt == BAUD_W'(`UART_CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_cmd_pkg::DES_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        uart_cmd_pkg::DES_IDLE: begin
          if (fall) begin
            baud_cnt <= '0;
            state    <= uart_cmd_pkg::DES_START;
          end
        end
        uart_cmd_pkg::DES_START: begin
          if (half_bit) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // glitch if the line went back high
            state    <= rx_sync ? uart_cmd_pkg::DES_IDLE : uart_cmd_pkg::DES_BITS;
          end else begin
            baud_cnt <= baud_cnt + BAUD_W'(1);
          end
        end
        uart_cmd_pkg::DES_BITS: begin
          if (full_bit) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 4'd1;
            // eight data bits plus parity
            if (bit_cnt == 4'(`UART_DATA_W)) begin
              state <= uart_cmd_pkg::DES_STOP;
            end
          end else begin
            baud_cnt <= baud_cnt + BAUD_W'(1);
          end
        end
        uart_cmd_pkg::DES_STOP: begin
          if (full_bit) begin
            baud_cnt <= '0;
            state    <= uart_cmd_pkg::DES_IDLE;
          end else begin
            baud_cnt <= baud_cnt + BAUD_W'(1);
          end
        end
        default: state <= uart_cmd_pkg::DES_IDLE;
      endcase
    end
  end

  // lsb arrives first, parity ends up on top
  always_ff @(posedge clk) begin
    if (state == uart_cmd_pkg::DES_BITS && full_bit) begin
      shreg <= {rx_sync, shreg[`UART_DATA_W:1]};
    end
  end

  assign parity_bad = (shreg[`UART_DATA_W] != ~^shreg[`UART_DATA_W-1:0]);

  // stop bit sampled live in this cycle
  assign frame_valid        = (state == uart_cmd_pkg::DES_STOP) && full_bit;
  assign frame_result.data  = shreg[`UART_DATA_W-1:0];
  assign frame_result.error = parity_bad || !rx_sync;

endmodule

`default_nettype wire

// File: design/uart_cmd_bridge.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_cmd_settings.svh"

module uart_cmd_bridge (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire uart_cmd_pkg::cmd_word_t   cmd,
  input  wire                            cmd_valid,
  output logic                           cmd_ready,
  output uart_cmd_pkg::rx_result_t       rd_result,
  output logic                           rd_valid,
  input  wire                            rd_ready,
  output logic                           tx,
  input  wire                            rx
);

  uart_cmd_pkg::byte_req_t  byte_req;
  logic                     byte_valid;
  logic                     byte_ready;
  uart_cmd_pkg::rx_result_t frame_result;
  logic                     frame_valid;

  cmd_sequencer seq_u (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .byte_req     (byte_req),
    .byte_valid   (byte_valid),
    .byte_ready   (byte_ready),
    .frame_result (frame_result),
    .frame_valid  (frame_valid),
    .rd_result    (rd_result),
    .rd_valid     (rd_valid),
    .rd_ready     (rd_ready)
  );

  frame_serializer ser_u (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_req   (byte_req),
    .byte_valid (byte_valid),
    .byte_ready (byte_ready),
    .tx         (tx)
  );

  // response path, no back-pressure
  frame_deserializer des_u (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx           (rx),
    .frame_result (frame_result),
    .frame_valid  (frame_valid)
  );

endmodule

`default_nettype wire

// File: verification/uart_slave_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_cmd_settings.svh"

module uart_slave_model (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        tx,
  output logic       rx,
  input  wire  [4:0] reply_gap,
  input  wire        corrupt_parity,
  output logic       frame_seen,
  output logic [7:0] frame_byte,
  output logic       frame_parity,
  output logic       frame_stop
);

  logic [7:0] regs [0:127];
  logic [9:0] bits;
  logic       write_pending;
  logic [6:0] write_addr;

  task automatic wait_bits(input int n);
    repeat (n * `UART_CLKS_PER_BIT) @(negedge clk);
  endtask

  // reply frame on rx with parity optionally flipped
  task automatic send_frame(input logic [7:0] data, input logic flip);
    logic [10:0] frame;
    frame = {1'b1, (~^data) ^ flip, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      rx = frame[i];
      // the idle line holds the stop bit, so the next header is not missed
      if (i < 10) begin
        repeat (`UART_CLKS_PER_BIT) @(negedge clk);
      end
    end
  endtask

  initial begin
    for (int a = 0; a < 128; a++) begin
      regs[a] = 8'(a) ^ 8'h5A;
    end
    rx            = 1'b1;
    frame_seen    = 1'b0;
    frame_byte    = 8'h00;
    frame_parity  = 1'b0;
    frame_stop    = 1'b0;
    write_pending = 1'b0;
    write_addr    = 7'h00;
    @(posedge rst_n);
    forever begin
      @(negedge tx);
      repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
      // start bit must still be low at mid-bit
      if (tx == 1'b0) begin
        for (int i = 0; i < 10; i++) begin
          repeat (`UART_CLKS_PER_BIT) @(negedge clk);
          bits[i] = tx;
        end
        @(posedge clk);
        #2;
        frame_byte   = bits[7:0];
        frame_parity = bits[8];
        frame_stop   = bits[9];
        frame_seen   = 1'b1;
        @(posedge clk);
        #2;
        frame_seen = 1'b0;
        if (write_pending) begin
          regs[write_addr] = frame_byte;
          write_pending    = 1'b0;
        end else if (frame_byte[7]) begin
          write_pending = 1'b1;
          write_addr    = frame_byte[6:0];
        end else begin
          wait_bits(int'(reply_gap));
          send_frame(regs[frame_byte[6:0]], corrupt_parity);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_uart_cmd_bridge.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_cmd_settings.svh"

module tb_uart_cmd_bridge;

  localparam int TIMEOUT_CYCLES = 60 * 40 * `UART_CLKS_PER_BIT * 2;

  logic                     clk;
  logic                     rst_n;
  uart_cmd_pkg::cmd_word_t  cmd;
  logic                     cmd_valid;
  logic                     cmd_ready;
  uart_cmd_pkg::rx_result_t rd_result;
  logic                     rd_valid;
  logic                     rd_ready;
  logic                     tx;
  logic                     rx;
  logic [4:0]               reply_gap;
  logic                     corrupt_parity;
  logic                     frame_seen;
  logic [7:0]               frame_byte;
  logic                     frame_parity;
  logic                     frame_stop;

  logic [15:0]              lfsr;
  logic [7:0]               shadow_data [0:127];
  logic                     shadow_valid [0:127];
  uart_cmd_pkg::rx_result_t exp_reads [0:255];
  logic [7:0]               exp_frames [0:255];
  int                       n_reads = 0;
  int                       n_frames = 0;
  int                       reads_checked = 0;
  int                       frames_checked = 0;
  int                       mismatches = 0;
  int                       other_errors = 0;
  int                       cycles = 0;
  logic                     started = 1'b0;
  logic                     held_valid = 1'b0;
  uart_cmd_pkg::rx_result_t held_result;

  uart_cmd_bridge UUT (.*);
  uart_slave_model slave_u (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr, stepped once per bit taken
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // never-written locations read back as addr ^ 0x5A
  function automatic logic [7:0] predict_read(input logic [6:0] addr);
    if (shadow_valid[addr]) begin
      return shadow_data[addr];
    end
    return {1'b0, addr} ^ 8'h5A;
  endfunction

  task automatic issue_cmd(input uart_cmd_pkg::cmd_op_e op, input logic [6:0] addr,
                           input logic [7:0] data, input logic corrupt);
    uart_cmd_pkg::rx_result_t exp_r;
    int stall;
    exp_frames[n_frames] = {op == uart_cmd_pkg::OP_WRITE, addr};
    n_frames++;
    if (op == uart_cmd_pkg::OP_WRITE) begin
      exp_frames[n_frames] = data;
      n_frames++;
      shadow_data[addr]  = data;
      shadow_valid[addr] = 1'b1;
    end else begin
      exp_r.data  = predict_read(addr);
      exp_r.error = corrupt;
      exp_reads[n_reads] = exp_r;
      n_reads++;
      reply_gap      = 5'(2 + rand_bits(5) % 19);
      corrupt_parity = corrupt;
    end
    cmd.op    = op;
    cmd.addr  = addr;
    cmd.data  = data;
    cmd_valid = 1'b1;
    while (!cmd_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    if (op == uart_cmd_pkg::OP_READ) begin
      stall = rand_bits(4);
      while (!rd_valid) begin
        @(posedge clk);
        #1;
      end
      repeat (stall) begin
        @(posedge clk);
        #1;
      end
      rd_ready = 1'b1;
      @(posedge clk);
      #1;
      rd_ready       = 1'b0;
      corrupt_parity = 1'b0;
    end
  endtask

  task automatic report_and_finish(input logic timed_out);
    $display("mismatches: %0d, other errors: %0d, timeout: %0d, reads: %0d, frames: %0d",
             mismatches, other_errors, timed_out, reads_checked, frames_checked);
    if (!timed_out && mismatches == 0 && other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  initial begin
    logic       op_bit;
    logic [6:0] addr;
    logic [7:0] data;
    logic       corrupt;
    rst_n          = 1'b0;
    cmd            = '0;
    cmd_valid      = 1'b0;
    rd_ready       = 1'b0;
    reply_gap      = 5'd2;
    corrupt_parity = 1'b0;
    lfsr           = 16'd52537;
    for (int a = 0; a < 128; a++) begin
      shadow_valid[a] = 1'b0;
    end
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    // idle window before the first command
    repeat (20) @(posedge clk);
    #1 started = 1'b1;
    issue_cmd(uart_cmd_pkg::OP_WRITE, 7'h15, 8'hC3, 1'b0);
    issue_cmd(uart_cmd_pkg::OP_READ, 7'h15, 8'h00, 1'b0);
    issue_cmd(uart_cmd_pkg::OP_READ, 7'h40, 8'h00, 1'b0);
    issue_cmd(uart_cmd_pkg::OP_READ, 7'h15, 8'h00, 1'b1);
    issue_cmd(uart_cmd_pkg::OP_READ, 7'h15, 8'h00, 1'b0);
    for (int i = 0; i < 60; i++) begin
      op_bit  = rand_bits(1) != 0;
      addr    = 7'(rand_bits(5));
      data    = 8'(rand_bits(8));
      corrupt = rand_bits(3) == 0;
      issue_cmd(op_bit ? uart_cmd_pkg::OP_WRITE : uart_cmd_pkg::OP_READ, addr, data, corrupt);
    end
    while (frames_checked < n_frames || reads_checked < n_reads) begin
      @(posedge clk);
      #1;
    end
    report_and_finish(1'b0);
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (!started) begin
        assert (tx === 1'b1 && rd_valid === 1'b0 && cmd_ready === 1'b1) else begin
          mismatches++;
          $display("Mismatch at %0t: idle tx=%b rd_valid=%b cmd_ready=%b",
                   $time, tx, rd_valid, cmd_ready);
        end
      end
      if (rd_valid) begin
        assert (!cmd_ready) else begin
          other_errors++;
          $display("cmd_ready was high at %0t while a read result was pending", $time);
        end
        if (held_valid) begin
          assert (rd_result == held_result) else begin
            mismatches++;
            $display("Mismatch at %0t: rd_result moved from %h to %h while stalled",
                     $time, held_result, rd_result);
          end
        end
        held_valid  = !rd_ready;
        held_result = rd_result;
        if (rd_ready && reads_checked >= n_reads) begin
          other_errors++;
          $display("a read result was taken at %0t with no read outstanding", $time);
        end else if (rd_ready) begin
          assert (rd_result == exp_reads[reads_checked]) else begin
            mismatches++;
            $display("Mismatch at %0t: read got %h, expected %h",
                     $time, rd_result, exp_reads[reads_checked]);
          end
          reads_checked++;
        end
      end else begin
        held_valid = 1'b0;
      end
      if (frame_seen && frames_checked >= n_frames) begin
        other_errors++;
        $display("the slave decoded an unexpected frame %h at %0t", frame_byte, $time);
      end else if (frame_seen) begin
        // odd parity over data plus parity bit, stop high
        assert (frame_byte == exp_frames[frames_checked] && ^{frame_parity, frame_byte}
                && frame_stop) else begin
          mismatches++;
          $display("Mismatch at %0t: frame %h parity %b stop %b, expected byte %h",
                   $time, frame_byte, frame_parity, frame_stop, exp_frames[frames_checked]);
        end
        frames_checked++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles with work still pending", cycles);
      report_and_finish(1'b1);
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/uart_cmd_pkg.sv
design/cmd_sequencer.sv
design/frame_serializer.sv
design/frame_deserializer.sv
design/uart_cmd_bridge.sv
verification/uart_slave_model.sv
verification/tb_uart_cmd_bridge.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_uart_cmd_bridge -f filelist.f
out=$(./obj_dir/Vtb_uart_cmd_bridge)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'all tests passed'; then
  exit 0
fi
exit 1
